// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    // instruction length in bytes
    localparam int instr_len = 4;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_width-1:0] reg_idx_t;

    // major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        load     = 5'b00000,
        misc_mem = 5'b00011,
        op_imm   = 5'b00100,
        auipc    = 5'b00101,
        store    = 5'b01000,
        op       = 5'b01100,
        lui      = 5'b01101,
        branch   = 5'b11000,
        jalr     = 5'b11001,
        jal      = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        st_reset,
        st_fetch,
        st_decode,
        st_exec,
        st_load,
        st_store,
        st_branch
    } state_e;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // alu groups, shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // lw and sw
    localparam logic [2:0] f3_word = 3'b010;

    // bit inside funct7 that picks sub and sra
    localparam int funct7_alt_bit = 5;

endpackage

`default_nettype wire

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  logic              clk,
    input  logic              reset,
    input  logic              en,
    input  cpu_pkg::alu_op_e  op,
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    output cpu_pkg::word_t    result,
    output logic              lt,
    output logic              ltu,
    output logic              eq
);
    import cpu_pkg::*;

    word_t      calc;
    logic [4:0] shamt;
    logic       signed_lt;
    logic       unsigned_lt;

    assign shamt = b[4:0];
    assign signed_lt = $signed(a) < $signed(b);
    assign unsigned_lt = a < b;

    always_comb begin
        case (op)
            alu_add:  calc = a + b;
            alu_sub:  calc = a - b;
            alu_sll:  calc = a << shamt;
            alu_slt:  calc = {{(xlen-1){1'b0}}, signed_lt};
            alu_sltu: calc = {{(xlen-1){1'b0}}, unsigned_lt};
            alu_xor:  calc = a ^ b;
            alu_srl:  calc = a >> shamt;
            alu_sra:  calc = $signed(a) >>> shamt;
            alu_or:   calc = a | b;
            alu_and:  calc = a & b;
            default:  calc = a + b;
        endcase
    end

    // result and flags hold until the next en
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            lt <= 1'b0;
            ltu <= 1'b0;
            eq <= 1'b0;
        end else if (en) begin
            result <= calc;
            lt <= signed_lt;
            ltu <= unsigned_lt;
            eq <= (a == b);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder (
    input  logic              clk,
    input  logic              en,
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::reg_idx_t rs1,
    output cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::reg_idx_t rd,
    output cpu_pkg::word_t    imm,
    output cpu_pkg::opcode_e  opcode,
    output logic [2:0]        funct3,
    output logic              funct7_alt
);
    import cpu_pkg::*;

    opcode_e dec_op;
    word_t   imm_next;

    // codes outside the enum fall through as a no-op in control
    assign dec_op = opcode_e'(instr[6:2]);

    always_comb begin
        case (dec_op)
            store: begin
                imm_next = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            branch: begin
                imm_next = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            end
            lui, auipc: begin
                imm_next = {instr[31:12], 12'b0};
            end
            jal: begin
                imm_next = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            end
            // I-type for op_imm, load, jalr and the rest
            default: begin
                imm_next = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            rd <= instr[11:7];
            imm <= imm_next;
            opcode <= dec_op;
            funct3 <= instr[14:12];
            funct7_alt <= instr[25 + funct7_alt_bit];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic              clk,
    input  logic              re,
    input  logic              we,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
        if (re) begin
            rdata1 <= (rs1 == '0) ? '0 : regs[rs1];
            rdata2 <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_wb_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_wb_bus (
    input  logic           clk,
    input  logic           reset,
    input  logic           en,
    input  logic           we_req,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata,
    output logic           busy,
    input  logic           ack,
    input  cpu_pkg::word_t dat_r,
    output logic           cyc,
    output logic           stb,
    output logic           we,
    output cpu_pkg::word_t adr,
    output cpu_pkg::word_t dat_w
);

    // high for the one cycle after ack
    logic done;

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc <= 1'b0;
            we <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= cyc & ack;
            if (cyc) begin
                if (ack) begin
                    cyc <= 1'b0;
                    we <= 1'b0;
                end
            end else if (en) begin
                cyc <= 1'b1;
                we <= we_req;
            end
        end
    end

    // request held stable until ack
    always_ff @(posedge clk) begin
        if (!cyc && en) begin
            adr <= addr;
            dat_w <= wdata;
        end
        if (cyc && ack && !we) begin
            rdata <= dat_r;
        end
    end

    assign stb = cyc;
    assign busy = cyc | done;

endmodule

`default_nettype wire

// ==== verilog/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control #(
    parameter cpu_pkg::word_t reset_vector = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              bus_busy,
    input  cpu_pkg::word_t    bus_rdata,
    output logic              bus_en,
    output logic              bus_we,
    output cpu_pkg::word_t    bus_addr,
    output logic              dec_en,
    output cpu_pkg::word_t    instr,
    input  cpu_pkg::opcode_e  opcode,
    input  logic [2:0]        funct3,
    input  logic              funct7_alt,
    input  cpu_pkg::word_t    imm,
    output logic              reg_re,
    output logic              reg_we,
    output cpu_pkg::word_t    reg_wdata,
    input  cpu_pkg::word_t    rdata1,
    input  cpu_pkg::word_t    rdata2,
    output logic              alu_en,
    output cpu_pkg::alu_op_e  alu_op,
    output cpu_pkg::word_t    alu_a,
    output cpu_pkg::word_t    alu_b,
    input  cpu_pkg::word_t    alu_result,
    input  logic              lt,
    input  logic              ltu,
    input  logic              eq
);
    import cpu_pkg::*;

    state_e  state;
    word_t   pc;
    word_t   pc_next;
    word_t   pc_sel;
    word_t   fetch_pc;
    logic    nextpc_from_alu;
    logic    wb_from_alu;
    logic    wb_from_bus;
    logic    taken;
    alu_op_e arith_op;

    // decoder keeps its own copy once dec_en drops
    assign instr = bus_rdata;

    assign pc_sel = nextpc_from_alu ? alu_result : pc_next;
    assign fetch_pc = {pc_sel[xlen-1:2], 2'b00};

    always_comb begin
        case (funct3)
            f3_add_sub: arith_op = (opcode == op && funct7_alt) ? alu_sub : alu_add;
            f3_sll:     arith_op = alu_sll;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            f3_srl_sra: arith_op = funct7_alt ? alu_sra : alu_srl;
            f3_or:      arith_op = alu_or;
            default:    arith_op = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  taken = eq;
            f3_bne:  taken = !eq;
            f3_blt:  taken = lt;
            f3_bge:  taken = !lt;
            f3_bltu: taken = ltu;
            f3_bgeu: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // strobes and muxes per state
    always_comb begin
        bus_en = 1'b0;
        bus_we = 1'b0;
        bus_addr = alu_result;
        // keeps loading the decoder while the fetch completes
        dec_en = (state == st_decode);
        reg_re = 1'b0;
        reg_we = 1'b0;
        reg_wdata = alu_result;
        alu_en = 1'b0;
        alu_op = alu_add;
        alu_a = rdata1;
        alu_b = rdata2;
        if (!bus_busy) begin
            case (state)
                st_fetch: begin
                    bus_en = 1'b1;
                    bus_addr = fetch_pc;
                    // writeback of the previous instruction
                    reg_we = wb_from_alu | wb_from_bus;
                    if (wb_from_bus) begin
                        reg_wdata = bus_rdata;
                    end
                end
                st_decode: begin
                    reg_re = 1'b1;
                    // alu is idle, compute pc+4
                    alu_en = 1'b1;
                    alu_a = pc;
                    alu_b = word_t'(instr_len);
                end
                st_exec: begin
                    case (opcode)
                        op: begin
                            alu_en = 1'b1;
                            alu_op = arith_op;
                        end
                        op_imm: begin
                            alu_en = 1'b1;
                            alu_op = arith_op;
                            alu_b = imm;
                        end
                        load, store: begin
                            alu_en = 1'b1;
                            alu_b = imm;
                        end
                        jal, jalr: begin
                            // link value is the pc+4 from decode
                            reg_we = 1'b1;
                            alu_en = 1'b1;
                            alu_b = imm;
                            if (opcode == jal) begin
                                alu_a = pc;
                            end
                        end
                        branch: alu_en = 1'b1;
                        auipc: begin
                            alu_en = 1'b1;
                            alu_a = pc;
                            alu_b = imm;
                        end
                        lui: begin
                            reg_we = 1'b1;
                            reg_wdata = imm;
                        end
                        default: ;
                    endcase
                end
                st_load: bus_en = 1'b1;
                st_store: begin
                    bus_en = 1'b1;
                    bus_we = 1'b1;
                end
                st_branch: begin
                    // target in case the branch is taken
                    alu_en = 1'b1;
                    alu_a = pc;
                    alu_b = imm;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
            nextpc_from_alu <= 1'b0;
            wb_from_alu <= 1'b0;
            wb_from_bus <= 1'b0;
        end else if (!bus_busy) begin
            case (state)
                st_reset: state <= st_fetch;
                st_fetch: begin
                    wb_from_alu <= 1'b0;
                    wb_from_bus <= 1'b0;
                    state <= st_decode;
                end
                st_decode: begin
                    nextpc_from_alu <= 1'b0;
                    state <= st_exec;
                end
                st_exec: begin
                    state <= st_fetch;
                    case (opcode)
                        op, op_imm, auipc: wb_from_alu <= 1'b1;
                        load: state <= st_load;
                        store: state <= st_store;
                        branch: state <= st_branch;
                        jal, jalr: nextpc_from_alu <= 1'b1;
                        default: ;
                    endcase
                end
                st_load: begin
                    wb_from_bus <= 1'b1;
                    state <= st_fetch;
                end
                st_branch: begin
                    nextpc_from_alu <= taken;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!bus_busy) begin
            case (state)
                st_reset: pc_next <= reset_vector;
                st_fetch: pc <= fetch_pc;
                // alu holds pc+4 here
                st_exec: pc_next <= alu_result;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter cpu_pkg::word_t reset_vector = '0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           ack,
    input  cpu_pkg::word_t dat_r,
    output logic           cyc,
    output logic           stb,
    output logic           we,
    output cpu_pkg::word_t adr,
    output cpu_pkg::word_t dat_w
);
    import cpu_pkg::*;

    logic     bus_en;
    logic     bus_we;
    logic     bus_busy;
    word_t    bus_addr;
    word_t    bus_rdata;
    logic     dec_en;
    word_t    instr;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    opcode_e  opcode;
    logic [2:0] funct3;
    logic     funct7_alt;
    logic     reg_re;
    logic     reg_we;
    word_t    reg_wdata;
    word_t    rdata1;
    word_t    rdata2;
    logic     alu_en;
    alu_op_e  alu_op;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     lt;
    logic     ltu;
    logic     eq;

    cpu_control #(
        .reset_vector(reset_vector)
    ) i_control (
        .clk(clk), .reset(reset),
        .bus_busy(bus_busy), .bus_rdata(bus_rdata),
        .bus_en(bus_en), .bus_we(bus_we), .bus_addr(bus_addr),
        .dec_en(dec_en), .instr(instr), .opcode(opcode),
        .funct3(funct3), .funct7_alt(funct7_alt), .imm(imm),
        .reg_re(reg_re), .reg_we(reg_we), .reg_wdata(reg_wdata),
        .rdata1(rdata1), .rdata2(rdata2),
        .alu_en(alu_en), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_result(alu_result), .lt(lt), .ltu(ltu), .eq(eq)
    );

    cpu_alu i_alu (
        .clk(clk), .reset(reset), .en(alu_en), .op(alu_op),
        .a(alu_a), .b(alu_b), .result(alu_result),
        .lt(lt), .ltu(ltu), .eq(eq)
    );

    cpu_decoder i_decoder (
        .clk(clk), .en(dec_en), .instr(instr),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .opcode(opcode), .funct3(funct3), .funct7_alt(funct7_alt)
    );

    cpu_regfile i_regfile (
        .clk(clk), .re(reg_re), .we(reg_we),
        .rs1(rs1), .rs2(rs2), .rd(rd), .wdata(reg_wdata),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    // store data comes straight from the second read port
    cpu_wb_bus i_wb_bus (
        .clk(clk), .reset(reset),
        .en(bus_en), .we_req(bus_we), .addr(bus_addr), .wdata(rdata2),
        .rdata(bus_rdata), .busy(bus_busy),
        .ack(ack), .dat_r(dat_r),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w)
    );

endmodule

`default_nettype wire

// ==== dv/tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
    enc_r = {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic word_t enc_i(input opcode_e opc, input logic [2:0] f3, input reg_idx_t rd,
                                input reg_idx_t rs1, input logic [11:0] imm);
    enc_i = {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic word_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1, input logic [11:0] imm);
    enc_s = {imm[11:5], rs2, rs1, f3_word, imm[4:0], store, 2'b11};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                input logic [12:0] imm);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], branch, 2'b11};
endfunction

function automatic word_t enc_u(input opcode_e opc, input reg_idx_t rd, input logic [19:0] imm);
    enc_u = {imm, rd, opc, 2'b11};
endfunction

function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, jal, 2'b11};
endfunction

// rv32i integer operation, alt selects sub or sra
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
    word_t r;
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = {31'b0, $signed(a) < $signed(b)};
        3'b011: r = {31'b0, a < b};
        3'b100: r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// interpreter over ref_mem, fills the expected fetch and store queues
task automatic run_model();
    word_t x [0:31];
    word_t pc;
    word_t next_pc;
    word_t ins;
    word_t a;
    word_t b;
    word_t res;
    word_t addr;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic [2:0] f3;
    logic wr;
    logic taken;
    logic stop;
    int steps;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = reset_vector;
    stop = 1'b0;
    steps = 0;
    while (!stop && steps < 10000) begin
        ins = ref_mem[pc[13:2]];
        exp_fetch.push_back(pc);
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        a = x[ins[19:15]];
        b = x[ins[24:20]];
        next_pc = pc + 32'd4;
        wr = 1'b0;
        res = '0;
        case (opcode_e'(ins[6:2]))
            op: begin
                res = alu_ref(f3, ins[30], a, b);
                wr = 1'b1;
            end
            op_imm: begin
                res = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
                wr = 1'b1;
            end
            lui: begin
                res = imm_u;
                wr = 1'b1;
            end
            auipc: begin
                res = pc + imm_u;
                wr = 1'b1;
            end
            jal: begin
                res = pc + 32'd4;
                wr = 1'b1;
                next_pc = pc + imm_j;
                stop = (imm_j == 32'd0);
            end
            jalr: begin
                res = pc + 32'd4;
                wr = 1'b1;
                next_pc = (a + imm_i) & ~32'd3;
            end
            branch: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    3'b111: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            load: begin
                addr = a + imm_i;
                res = ref_mem[addr[13:2]];
                wr = 1'b1;
            end
            store: begin
                addr = a + imm_s;
                ref_mem[addr[13:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        pc = {next_pc[31:2], 2'b00};
        steps++;
    end
endtask

`endif

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t reset_vector = 32'h0000_0200;
    localparam int num_instr = 200;
    localparam int timeout_cycles = num_instr * 4 * 5 + 1000;

    logic  clk;
    logic  reset;
    logic  ack;
    word_t dat_r;
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t dat_w;

    int    seed = 32'h02cc_2acb;
    int    errors = 0;
    int    cycles = 0;
    int    prog_len = 0;
    int    store_cnt = 0;
    int    fetch_cnt = 0;
    logic  done = 1'b0;
    logic  [1:0] wait_left;
    word_t mem [0:4095];
    word_t ref_mem [0:4095];
    word_t exp_fetch [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    logic  prev_cyc = 1'b0;
    logic  prev_ack = 1'b0;
    logic  prev_we = 1'b0;
    word_t prev_adr = '0;
    word_t prev_dat_w = '0;

    `include "tb_cpu_model.svh"

    cpu #(
        .reset_vector(reset_vector)
    ) i_dut (
        .clk(clk), .reset(reset), .ack(ack), .dat_r(dat_r),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic word_t rnd();
        rnd = $random(seed);
    endfunction

    // program sits at the reset vector
    task automatic emit(input word_t ins);
        mem[reset_vector[13:2] + prog_len[11:0]] = ins;
        prog_len++;
    endtask

    // each result goes to the next slot of the store area at x31
    task automatic emit_store(input reg_idx_t rd);
        emit(enc_s(rd, 5'd31, 12'(store_cnt * 4)));
        store_cnt++;
    endtask

    task automatic emit_filler(input word_t w);
        emit(enc_i(op_imm, f3_xor, {1'b0, w[27:24]}, {1'b0, w[31:28]}, w[31:20]));
    endtask

    task automatic build_program();
        word_t w;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [2:0] f3;
        logic alt;
        logic [11:0] imm;
        for (int i = 0; i < 4096; i++) begin
            mem[i[11:0]] = 32'(i) * 32'h9e37_79b9;
        end
        // load area at 0x1000
        for (int i = 1024; i < 1280; i++) begin
            mem[i[11:0]] = rnd();
        end
        emit(enc_u(lui, 5'd30, 20'h00001));
        emit(enc_u(lui, 5'd31, 20'h00002));
        for (int r = 1; r < 16; r++) begin
            w = rnd();
            emit(enc_u(lui, 5'(r), w[31:12]));
            emit(enc_i(op_imm, f3_add_sub, 5'(r), 5'(r), w[11:0]));
        end
        while (prog_len < num_instr - 5) begin
            w = rnd();
            rd = {1'b0, w[3:0]};
            rs1 = {1'b0, w[7:4]};
            rs2 = {1'b0, w[11:8]};
            f3 = w[14:12];
            alt = w[15] && (f3 == f3_add_sub || f3 == f3_srl_sra);
            case (w[19:16])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    emit(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
                    emit_store(rd);
                end
                4'd4, 4'd5, 4'd6: begin
                    if (f3 == f3_sll) begin
                        imm = {7'b0, w[24:20]};
                    end else if (f3 == f3_srl_sra) begin
                        imm = {1'b0, alt, 5'b0, w[24:20]};
                    end else begin
                        imm = w[31:20];
                    end
                    emit(enc_i(op_imm, f3, rd, rs1, imm));
                    emit_store(rd);
                end
                4'd7: begin
                    emit(enc_u(lui, rd, w[31:12]));
                    emit_store(rd);
                end
                4'd8: begin
                    emit(enc_u(auipc, rd, w[31:12]));
                    emit_store(rd);
                end
                4'd9: begin
                    emit(enc_i(load, f3_word, rd, 5'd30, {2'b0, w[27:20], 2'b0}));
                    emit_store(rd);
                end
                4'd10, 4'd11: begin
                    // funct3 010 and 011 are not branches
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    if (w[23]) begin
                        rs2 = rs1;
                    end
                    emit(enc_b(f3, rs1, rs2, w[20] ? 13'd12 : 13'd8));
                    emit_filler(w);
                    if (w[20]) begin
                        emit_filler(~w);
                    end
                end
                4'd12: begin
                    emit(enc_j(rd, 21'd8));
                    emit_filler(w);
                    emit_store(rd);
                end
                4'd13: begin
                    // odd offset rounds the target down to the store
                    emit(enc_u(auipc, 5'd29, 20'h0));
                    emit(enc_i(jalr, 3'b000, rd, 5'd29, 12'd13));
                    emit_filler(w);
                    emit_store(rd);
                end
                4'd14: emit(enc_i(misc_mem, 3'b000, 5'd0, 5'd0, 12'h0ff));
                default: begin
                    emit(enc_i(op_imm, f3_add_sub, 5'd0, rs1, w[31:20]));
                    emit_store(5'd0);
                end
            endcase
        end
        while (prog_len < num_instr - 1) begin
            emit(enc_i(misc_mem, 3'b000, 5'd0, 5'd0, 12'h0ff));
        end
        emit(enc_j(5'd0, 21'd0));
    endtask

    // memory slave with 0 to 3 wait states
    always @(posedge clk) begin
        word_t draw;
        if (reset) begin
            ack <= 1'b0;
            wait_left <= 2'd0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc) begin
            if (wait_left == 2'd0) begin
                ack <= 1'b1;
                if (we) begin
                    mem[adr[13:2]] = dat_w;
                end else begin
                    dat_r <= mem[adr[13:2]];
                end
                draw = rnd();
                wait_left <= draw[1:0];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // bus protocol and transaction checks
    always @(posedge clk) begin
        if (reset) begin
            // the first edge only loads the reset values
            if (cycles > 0 && (cyc !== 1'b0 || stb !== 1'b0)) begin
                $display("bus cycle started while reset was high");
                errors++;
            end
        end else begin
            if (prev_cyc && !prev_ack) begin
                if (!cyc || !stb) begin
                    $display("cyc or stb dropped before ack at %h", prev_adr);
                    errors++;
                end
                check("bus adr hold", prev_adr, adr);
                check("bus dat_w hold", prev_dat_w, dat_w);
                check("bus we hold", {31'b0, prev_we}, {31'b0, we});
            end
            if (prev_cyc && prev_ack && (cyc || stb)) begin
                $display("cyc or stb still high on the cycle after ack");
                errors++;
            end
            if (cyc && ack) begin
                if (we) begin
                    if (exp_addr.size() == 0) begin
                        $display("unexpected store of %h to %h", dat_w, adr);
                        errors++;
                    end else begin
                        check("store address", exp_addr.pop_front(), adr);
                        check("store data", exp_data.pop_front(), dat_w);
                    end
                end else if (adr < 32'h0000_1000 && !done) begin
                    if (fetch_cnt == 0) begin
                        check("first fetch", reset_vector, adr);
                    end
                    fetch_cnt++;
                    check("fetch address", exp_fetch.pop_front(), adr);
                    done = (exp_fetch.size() == 0);
                end
            end
        end
        prev_cyc = cyc;
        prev_ack = ack;
        prev_we = we;
        prev_adr = adr;
        prev_dat_w = dat_w;
    end

    initial begin
        reset <= 1'b1;
        ack <= 1'b0;
        dat_r <= '0;
        build_program();
        ref_mem = mem;
        run_model();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!done && cycles < timeout_cycles) begin
            @(posedge clk);
        end
        if (!done) begin
            $display("core hung, final jump not fetched after %0d cycles", cycles);
            errors++;
        end else if (exp_addr.size() != 0) begin
            $display("%0d expected stores never happened", exp_addr.size());
            errors++;
        end
        $display("fetches: %0d stores: %0d errors: %0d", fetch_cnt, store_cnt, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+dv
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_decoder.sv
verilog/cpu_regfile.sv
verilog/cpu_wb_bus.sv
verilog/cpu_control.sv
verilog/cpu.sv
dv/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
FLIST     ?= flist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
